// File: flist.f
+incdir+logic
logic/isa_pkg.sv
logic/rob_pkg.sv
logic/rename_regfile.sv
logic/reorder_buffer.sv
logic/alu_station.sv
logic/alu_unit.sv
logic/ooo_core.sv
test/tb_ooo_core.sv

// File: logic/alu_station.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module alu_station (
    input  logic              clk,
    input  logic              rst,
    input  logic              rs_alloc,
    input  isa_pkg::opcode_t  rs_op,
    input  rob_pkg::rob_tag_t rs_tag,
    input  logic [`XLEN-1:0]  rs_v1,
    input  rob_pkg::rob_tag_t rs_q1,
    input  logic [`XLEN-1:0]  rs_v2,
    input  rob_pkg::rob_tag_t rs_q2,
    input  logic [`XLEN-1:0]  rs_pc,
    input  logic [`XLEN-1:0]  rs_imm,
    output logic              rs_full,
    input  logic              cdb_valid,
    input  rob_pkg::rob_tag_t cdb_tag,
    input  logic [`XLEN-1:0]  cdb_value,
    output logic              iss_valid,
    output isa_pkg::opcode_t  iss_op,
    output logic [`XLEN-1:0]  iss_a,
    output logic [`XLEN-1:0]  iss_b,
    output logic [`XLEN-1:0]  iss_pc,
    output logic [`XLEN-1:0]  iss_imm,
    output rob_pkg::rob_tag_t iss_tag
);
    import isa_pkg::*;
    import rob_pkg::*;

    logic [`RS_DEPTH-1:0] valid;
    logic [`RS_DEPTH-1:0] ready;
    opcode_t op [`RS_DEPTH];
    rob_tag_t tag [`RS_DEPTH];
    rob_tag_t q1 [`RS_DEPTH];
    rob_tag_t q2 [`RS_DEPTH];
    logic [`XLEN-1:0] v1 [`RS_DEPTH];
    logic [`XLEN-1:0] v2 [`RS_DEPTH];
    logic [`XLEN-1:0] pc [`RS_DEPTH];
    logic [`XLEN-1:0] imm [`RS_DEPTH];
    logic oldest;
    logic sel;
    logic slot;

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready[i] = valid[i] && q1[i] == '0 && q2[i] == '0;
        end
    end

    assign rs_full = &valid;
    assign slot = valid[0];  // first free entry
    assign sel = ready[oldest] ? oldest : ~oldest;
    assign iss_valid = |ready;
    assign iss_op = op[sel];
    assign iss_a = v1[sel];
    assign iss_b = v2[sel];
    assign iss_pc = pc[sel];
    assign iss_imm = imm[sel];
    assign iss_tag = tag[sel];

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid <= '0;
            oldest <= 1'b0;
        end else begin
            if (iss_valid)
                valid[sel] <= 1'b0;
            if (rs_alloc) begin
                valid[slot] <= 1'b1;
                // an issue on this edge always empties the other entry
                oldest <= (valid[~slot] && !iss_valid) ? ~slot : slot;
            end else if (iss_valid) begin
                oldest <= ~sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (cdb_valid && q1[i] == cdb_tag) begin
                v1[i] <= cdb_value;
                q1[i] <= '0;
            end
            if (cdb_valid && q2[i] == cdb_tag) begin
                v2[i] <= cdb_value;
                q2[i] <= '0;
            end
        end
        if (rs_alloc) begin
            op[slot] <= rs_op;
            tag[slot] <= rs_tag;
            v1[slot] <= rs_v1;
            q1[slot] <= rs_q1;
            v2[slot] <= rs_v2;
            q2[slot] <= rs_q2;
            pc[slot] <= rs_pc;
            imm[slot] <= rs_imm;
        end
    end

    a_no_fill_full: assert property (@(posedge clk) disable iff (!rst) rs_alloc |-> !rs_full);
endmodule

// File: logic/alu_unit.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              iss_valid,
    input  isa_pkg::opcode_t  iss_op,
    input  logic [`XLEN-1:0]  iss_a,
    input  logic [`XLEN-1:0]  iss_b,
    input  logic [`XLEN-1:0]  iss_pc,
    input  logic [`XLEN-1:0]  iss_imm,
    input  rob_pkg::rob_tag_t iss_tag,
    output logic              cdb_valid,
    output rob_pkg::rob_tag_t cdb_tag,
    output logic [`XLEN-1:0]  cdb_value,
    output logic              cdb_taken
);
    import isa_pkg::*;

    logic [`XLEN-1:0] result;
    logic cond;

    always_comb begin
        result = '0;
        cond = 1'b0;
        case (iss_op)
            ADD:  result = iss_a + iss_b;
            SUB:  result = iss_a - iss_b;
            AND:  result = iss_a & iss_b;
            OR:   result = iss_a | iss_b;
            XOR:  result = iss_a ^ iss_b;
            SLL:  result = iss_a << iss_b[4:0];
            SRL:  result = iss_a >> iss_b[4:0];
            SRA:  result = $signed(iss_a) >>> iss_b[4:0];
            SLT:  result = `XLEN'($signed(iss_a) < $signed(iss_b));
            SLTU: result = `XLEN'(iss_a < iss_b);
            JALR: result = (iss_a + iss_imm) & ~`XLEN'(1);
            BEQ:  cond = iss_a == iss_b;
            BNE:  cond = iss_a != iss_b;
            BLT:  cond = $signed(iss_a) < $signed(iss_b);
            BGE:  cond = $signed(iss_a) >= $signed(iss_b);
            BLTU: cond = iss_a < iss_b;
            BGEU: cond = iss_a >= iss_b;
            default: ;
        endcase
        if (is_branch(iss_op))
            result = iss_pc + iss_imm;  // branch target rides along for debug
    end

    always_ff @(posedge clk) begin
        if (!rst)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= iss_valid;
    end

    always_ff @(posedge clk) begin
        cdb_tag <= iss_tag;
        cdb_value <= result;
        cdb_taken <= cond;
    end
endmodule

// File: logic/isa_pkg.sv
package isa_pkg;
    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR,           // register or immediate arithmetic
        SLL, SRL, SRA, SLT, SLTU,
        LUI, AUIPC, JAL, JALR,            // upper immediates and jumps
        BEQ, BNE, BLT, BGE, BLTU, BGEU,   // conditional branches
        NOP
    } opcode_t;

    function automatic logic is_branch(opcode_t op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

    // these never visit the ALU and are finished once they are in the buffer
    function automatic logic done_at_dispatch(opcode_t op);
        return op inside {LUI, AUIPC, JAL, NOP};
    endfunction
endpackage

// File: logic/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

`define XLEN 32       // data and pc width
`define REG_NUM 32    // architectural registers
`define ROB_DEPTH 8   // slot 0 is reserved, so seven entries are live
`define RS_DEPTH 2    // reservation station entries

`endif

// File: logic/ooo_core.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    output logic                        disp_ready,
    input  isa_pkg::opcode_t            disp_op,
    input  logic [$clog2(`REG_NUM)-1:0] disp_rd,
    input  logic [$clog2(`REG_NUM)-1:0] disp_rs1,
    input  logic [$clog2(`REG_NUM)-1:0] disp_rs2,
    input  logic [`XLEN-1:0]            disp_imm,
    input  logic                        disp_has_imm,
    input  logic [`XLEN-1:0]            disp_pc,
    output logic                        commit_valid,
    output logic [$clog2(`REG_NUM)-1:0] commit_rd,
    output logic [`XLEN-1:0]            commit_value,
    output rob_pkg::rob_tag_t           commit_tag,
    output logic                        redirect_valid,
    output logic [`XLEN-1:0]            redirect_pc
);
    import isa_pkg::*;
    import rob_pkg::*;

    logic [$clog2(`REG_NUM)-1:0] rs1;
    logic [$clog2(`REG_NUM)-1:0] rs2;
    logic [`XLEN-1:0] rs1_value;
    logic [`XLEN-1:0] rs2_value;
    rob_tag_t rs1_tag;
    rob_tag_t rs2_tag;
    logic alloc_valid;
    logic [$clog2(`REG_NUM)-1:0] alloc_rd;
    rob_tag_t alloc_tag;
    logic rs_alloc;
    opcode_t rs_op;
    rob_tag_t rs_tag;
    logic [`XLEN-1:0] rs_v1;
    rob_tag_t rs_q1;
    logic [`XLEN-1:0] rs_v2;
    rob_tag_t rs_q2;
    logic [`XLEN-1:0] rs_pc;
    logic [`XLEN-1:0] rs_imm;
    logic rs_full;
    logic iss_valid;
    opcode_t iss_op;
    logic [`XLEN-1:0] iss_a;
    logic [`XLEN-1:0] iss_b;
    logic [`XLEN-1:0] iss_pc;
    logic [`XLEN-1:0] iss_imm;
    rob_tag_t iss_tag;
    logic cdb_valid;
    rob_tag_t cdb_tag;
    logic [`XLEN-1:0] cdb_value;
    logic cdb_taken;

    // all port names line up across the blocks
    rename_regfile u_regfile (.*);
    reorder_buffer u_rob (.*);
    alu_station u_station (.*);
    alu_unit u_alu (.*);
endmodule

// File: logic/rename_regfile.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module rename_regfile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(`REG_NUM)-1:0] rs1,
    input  logic [$clog2(`REG_NUM)-1:0] rs2,
    output logic [`XLEN-1:0]            rs1_value,
    output rob_pkg::rob_tag_t           rs1_tag,
    output logic [`XLEN-1:0]            rs2_value,
    output rob_pkg::rob_tag_t           rs2_tag,
    input  logic                        alloc_valid,
    input  logic [$clog2(`REG_NUM)-1:0] alloc_rd,
    input  rob_pkg::rob_tag_t           alloc_tag,
    input  logic                        commit_valid,
    input  logic [$clog2(`REG_NUM)-1:0] commit_rd,
    input  logic [`XLEN-1:0]            commit_value,
    input  rob_pkg::rob_tag_t           commit_tag
);
    import rob_pkg::*;

    logic [`XLEN-1:0] values [`REG_NUM];
    rob_tag_t tags [`REG_NUM];

    // a retiring producer is forwarded, since its buffer slot is already free
    always_comb begin
        rs1_value = values[rs1];
        rs1_tag = tags[rs1];
        if (rs1 == '0 || (commit_valid && commit_rd == rs1 && tags[rs1] == commit_tag)) begin
            rs1_value = (rs1 == '0) ? '0 : commit_value;
            rs1_tag = '0;
        end
        rs2_value = values[rs2];
        rs2_tag = tags[rs2];
        if (rs2 == '0 || (commit_valid && commit_rd == rs2 && tags[rs2] == commit_tag)) begin
            rs2_value = (rs2 == '0) ? '0 : commit_value;
            rs2_tag = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                tags[i] <= '0;
            end
        end else begin
            if (commit_valid && tags[commit_rd] == commit_tag)
                tags[commit_rd] <= '0;
            if (alloc_valid)
                tags[alloc_rd] <= alloc_tag;  // a new rename beats the clear
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid)
            values[commit_rd] <= commit_value;
    end

    a_reg0_tag: assert property (@(posedge clk) disable iff (!rst) tags[0] == '0);
endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module reorder_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    output logic                        disp_ready,
    input  isa_pkg::opcode_t            disp_op,
    input  logic [$clog2(`REG_NUM)-1:0] disp_rd,
    input  logic [$clog2(`REG_NUM)-1:0] disp_rs1,
    input  logic [$clog2(`REG_NUM)-1:0] disp_rs2,
    input  logic [`XLEN-1:0]            disp_imm,
    input  logic                        disp_has_imm,
    input  logic [`XLEN-1:0]            disp_pc,
    output logic [$clog2(`REG_NUM)-1:0] rs1,
    output logic [$clog2(`REG_NUM)-1:0] rs2,
    input  logic [`XLEN-1:0]            rs1_value,
    input  rob_pkg::rob_tag_t           rs1_tag,
    input  logic [`XLEN-1:0]            rs2_value,
    input  rob_pkg::rob_tag_t           rs2_tag,
    output logic                        alloc_valid,
    output logic [$clog2(`REG_NUM)-1:0] alloc_rd,
    output rob_pkg::rob_tag_t           alloc_tag,
    output logic                        rs_alloc,
    output isa_pkg::opcode_t            rs_op,
    output rob_pkg::rob_tag_t           rs_tag,
    output logic [`XLEN-1:0]            rs_v1,
    output rob_pkg::rob_tag_t           rs_q1,
    output logic [`XLEN-1:0]            rs_v2,
    output rob_pkg::rob_tag_t           rs_q2,
    output logic [`XLEN-1:0]            rs_pc,
    output logic [`XLEN-1:0]            rs_imm,
    input  logic                        rs_full,
    input  logic                        cdb_valid,
    input  rob_pkg::rob_tag_t           cdb_tag,
    input  logic [`XLEN-1:0]            cdb_value,
    input  logic                        cdb_taken,
    output logic                        commit_valid,
    output logic [$clog2(`REG_NUM)-1:0] commit_rd,
    output logic [`XLEN-1:0]            commit_value,
    output rob_pkg::rob_tag_t           commit_tag,
    output logic                        redirect_valid,
    output logic [`XLEN-1:0]            redirect_pc
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam rob_tag_t LIVE = rob_tag_t'(`ROB_DEPTH - 1);

    opcode_t ops [`ROB_DEPTH];
    logic [$clog2(`REG_NUM)-1:0] rds [`ROB_DEPTH];
    logic [`XLEN-1:0] values [`ROB_DEPTH];
    logic [`XLEN-1:0] targets [`ROB_DEPTH];
    entry_state_t states [`ROB_DEPTH];
    rob_tag_t head;
    rob_tag_t tail;
    rob_tag_t count;    // 0 to 7 live entries
    rob_tag_t cdb_off;  // distance of the bus tag from the head
    logic xfer;
    logic do_commit;
    logic use_imm;
    logic op1_ready;
    logic op2_ready;
    logic [`XLEN-1:0] op2_value;
    logic [`XLEN-1:0] entry_value;
    logic [$clog2(`REG_NUM)-1:0] entry_rd;

    function automatic rob_tag_t next_slot(rob_tag_t t);
        return (t == LIVE) ? rob_tag_t'(1) : t + 1'b1;
    endfunction

    // JALR holds pc plus 4 from dispatch while its bus value is the target
    function automatic logic [`XLEN:0] resolve(rob_tag_t tag, logic [`XLEN-1:0] rf_value);
        if (tag == '0)
            return {1'b1, rf_value};
        if (states[tag] != ENT_EXEC || ops[tag] == JALR)
            return {1'b1, values[tag]};
        if (cdb_valid && cdb_tag == tag)
            return {1'b1, cdb_value};
        return {1'b0, rf_value};
    endfunction

    always_comb begin
        {op1_ready, rs_v1} = resolve(rs1_tag, rs1_value);
        {op2_ready, op2_value} = resolve(rs2_tag, rs2_value);
        rs_q1 = op1_ready ? '0 : rs1_tag;
        rs_v2 = use_imm ? disp_imm : op2_value;
        rs_q2 = (use_imm || op2_ready) ? '0 : rs2_tag;
        case (disp_op)
            LUI:       entry_value = disp_imm;
            AUIPC:     entry_value = disp_pc + disp_imm;
            JAL, JALR: entry_value = disp_pc + `XLEN'(4);
            default:   entry_value = '0;
        endcase
    end

    assign use_imm = disp_has_imm && !is_branch(disp_op);
    assign entry_rd = is_branch(disp_op) ? '0 : disp_rd;
    assign disp_ready = (count != LIVE) && !(rs_full && !done_at_dispatch(disp_op));
    assign xfer = disp_valid && disp_ready;
    assign rs1 = disp_rs1;
    assign rs2 = disp_rs2;
    assign alloc_valid = xfer && entry_rd != '0;
    assign alloc_rd = entry_rd;
    assign alloc_tag = tail;
    assign rs_alloc = xfer && !done_at_dispatch(disp_op);
    assign rs_op = disp_op;
    assign rs_tag = tail;
    assign rs_pc = disp_pc;
    assign rs_imm = disp_imm;
    assign do_commit = count != '0 && states[head] != ENT_EXEC;
    assign cdb_off = (cdb_tag >= head) ? cdb_tag - head : cdb_tag + LIVE - head;

    always_ff @(posedge clk) begin
        if (!rst) begin
            head <= rob_tag_t'(1);
            tail <= rob_tag_t'(1);
            count <= '0;
            commit_valid <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (xfer)
                tail <= next_slot(tail);
            if (do_commit)
                head <= next_slot(head);
            count <= count + rob_tag_t'(xfer) - rob_tag_t'(do_commit);
            commit_valid <= do_commit;
            redirect_valid <= do_commit && (ops[head] inside {JAL, JALR} ||
                              (is_branch(ops[head]) && states[head] == ENT_DONE));
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_valid) begin
            if (is_branch(ops[cdb_tag]))
                states[cdb_tag] <= cdb_taken ? ENT_DONE : ENT_NOT_TAKEN;
            else
                states[cdb_tag] <= ENT_DONE;
            if (ops[cdb_tag] == JALR)
                targets[cdb_tag] <= cdb_value;
            else if (!is_branch(ops[cdb_tag]))
                values[cdb_tag] <= cdb_value;
        end
        if (xfer) begin
            ops[tail] <= disp_op;
            rds[tail] <= entry_rd;
            values[tail] <= entry_value;
            targets[tail] <= disp_pc + disp_imm;  // only read for JAL and branches
            states[tail] <= done_at_dispatch(disp_op) ? ENT_DONE : ENT_EXEC;
        end
        if (do_commit) begin
            commit_rd <= rds[head];
            commit_value <= values[head];
            commit_tag <= head;
            redirect_pc <= targets[head];
        end
    end

    // with seven live entries the tail has wrapped back onto the head
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        xfer |-> !(tail == head && count != '0));
    // results come back only for live entries still waiting on the ALU
    a_cdb_live: assert property (@(posedge clk) disable iff (!rst)
        cdb_valid |-> cdb_tag != '0 && cdb_off < count && states[cdb_tag] == ENT_EXEC);
endmodule

// File: logic/rob_pkg.sv
`include "ooo_consts.svh"

package rob_pkg;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;  // tag 0 means no producer

    typedef enum logic [1:0] {
        ENT_EXEC,       // waiting on the ALU
        ENT_DONE,       // free to retire
        ENT_NOT_TAKEN   // branch that fell through
    } entry_state_t;
endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f flist.f --top-module tb_ooo_core -o tb_ooo_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/tb_ooo_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

// File: test/tb_ooo_core.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module tb_ooo_core;
    import isa_pkg::*;

    localparam int NUM_INSTR = 300;
    localparam int WAIT_LIMIT = 100;     // cycles a dispatch may wait for disp_ready
    localparam int COMMIT_LIMIT = 100;   // cycles without a commit while work is outstanding
    localparam int DRAIN_LIMIT = 2000;

    logic clk;
    logic rst;
    logic disp_valid;
    logic disp_ready;
    opcode_t disp_op;
    logic [4:0] disp_rd;
    logic [4:0] disp_rs1;
    logic [4:0] disp_rs2;
    logic [`XLEN-1:0] disp_imm;
    logic disp_has_imm;
    logic [`XLEN-1:0] disp_pc;
    logic commit_valid;
    logic [4:0] commit_rd;
    logic [`XLEN-1:0] commit_value;
    rob_pkg::rob_tag_t commit_tag;
    logic redirect_valid;
    logic [`XLEN-1:0] redirect_pc;

    logic [31:0] lfsr = 32'hd58d;
    logic [`XLEN-1:0] regs [8];   // golden copy of x0 to x7
    logic [`XLEN-1:0] pc;
    opcode_t nx_op;
    logic [4:0] nx_rd;
    logic [4:0] nx_rs1;
    logic [4:0] nx_rs2;
    logic [`XLEN-1:0] nx_imm;
    logic nx_has_imm;
    logic [4:0] exp_rd_q [$];
    logic [`XLEN-1:0] exp_value_q [$];
    logic exp_check_q [$];        // branches leave commit_value undefined
    logic exp_redirect_q [$];
    logic [`XLEN-1:0] exp_target_q [$];
    int xfers = 0;
    int commits = 0;
    int idle = 0;
    int waited;
    logic started = 1'b0;
    logic stall_seen = 1'b0;

    ooo_core dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = lfsr_bits(3);
        return r[4:0];
    endfunction

    function automatic logic [`XLEN-1:0] alu_result(opcode_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            SLT:     return {31'b0, $signed(a) < $signed(b)};
            SLTU:    return {31'b0, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_taken(opcode_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // picks the next instruction and runs it through the golden model
    task automatic next_instr(input int n);
        logic [31:0] r;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] target;
        logic [4:0] rd;
        logic check;
        logic redirect;
        r = lfsr_bits(5) % 32'd20;
        nx_op = opcode_t'(r[4:0]);
        nx_rd = pick_reg();
        nx_rs1 = pick_reg();
        nx_rs2 = pick_reg();
        r = lfsr_bits(1);
        nx_has_imm = r[0];
        r = lfsr_bits(8);
        nx_imm = {{24{r[7]}}, r[7:0]};
        if (n < 7) begin           // give x1 to x7 known values first
            nx_op = ADD;
            nx_rd = 5'(n + 1);
            nx_rs1 = '0;
            nx_has_imm = 1'b1;
        end else if (nx_op == LUI) begin
            r = lfsr_bits(20);
            nx_imm = {r[19:0], 12'h0};
        end
        a = regs[nx_rs1[2:0]];
        rd = nx_rd;
        check = 1'b1;
        redirect = 1'b0;
        target = '0;
        case (nx_op)
            LUI:   value = nx_imm;
            AUIPC: value = pc + nx_imm;
            JAL: begin
                value = pc + 32'd4;
                redirect = 1'b1;
                target = pc + nx_imm;
            end
            JALR: begin
                value = pc + 32'd4;
                redirect = 1'b1;
                target = (a + nx_imm) & ~32'd1;
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                value = '0;
                rd = '0;
                check = 1'b0;
                redirect = branch_taken(nx_op, a, regs[nx_rs2[2:0]]);
                target = pc + nx_imm;
            end
            default: value = alu_result(nx_op, a, nx_has_imm ? nx_imm : regs[nx_rs2[2:0]]);
        endcase
        if (rd != '0)
            regs[rd[2:0]] = value;
        exp_rd_q.push_back(rd);
        exp_value_q.push_back(value);
        exp_check_q.push_back(check);
        exp_redirect_q.push_back(redirect);
        exp_target_q.push_back(target);
    endtask

    task automatic check_commit();
        logic [4:0] rd;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] target;
        logic check;
        logic redirect;
        int tag;
        rd = exp_rd_q.pop_front();
        value = exp_value_q.pop_front();
        check = exp_check_q.pop_front();
        redirect = exp_redirect_q.pop_front();
        target = exp_target_q.pop_front();
        tag = commits % 7 + 1;      // entries are handed out in turn over slots 1 to 7
        assert (commit_rd == rd)
            else fail_run($sformatf("Mismatch commit_rd: got %h expected %h", commit_rd, rd));
        assert (int'(commit_tag) == tag) else fail_run($sformatf(
            "Mismatch commit_tag: got %h expected %h", commit_tag, tag));
        if (check)
            assert (commit_value == value) else fail_run($sformatf(
                "Mismatch commit_value: got %h expected %h", commit_value, value));
        assert (redirect_valid == redirect) else fail_run($sformatf(
            "Mismatch redirect_valid: got %h expected %h", redirect_valid, redirect));
        if (redirect)
            assert (redirect_pc == target) else fail_run($sformatf(
                "Mismatch redirect_pc: got %h expected %h", redirect_pc, target));
    endtask

    // outputs are registered on the rising edge, so they are read on the falling one
    always @(negedge clk) begin
        if (rst) begin
            if (!started)
                assert (!commit_valid && !redirect_valid && disp_ready)
                    else fail_run("outputs were not idle between reset and the first dispatch");
            if (commit_valid) begin
                assert (exp_rd_q.size() > 0) else fail_run("commit arrived with nothing dispatched");
                check_commit();
                commits++;
                idle = 0;
                assert (commits <= xfers) else fail_run("more commits than transfers");
            end else begin
                assert (!redirect_valid) else fail_run("redirect raised without a commit");
                if (xfers != commits)
                    idle++;
                assert (idle < COMMIT_LIMIT) else fail_run("no commit arrived within the bound");
            end
            if (disp_valid && !disp_ready)
                stall_seen = 1'b1;
            if (disp_valid && disp_ready) begin   // transfer on the coming edge
                xfers++;
                started = 1'b1;
            end
            assert (xfers - commits <= 7) else fail_run("more than seven instructions outstanding");
        end
    end

    initial begin
        rst = 1'b0;
        disp_valid = 1'b0;
        disp_op = ADD;
        disp_rd = '0;
        disp_rs1 = '0;
        disp_rs2 = '0;
        disp_imm = '0;
        disp_has_imm = 1'b0;
        disp_pc = '0;
        pc = '0;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        for (int n = 0; n < NUM_INSTR; n++) begin
            next_instr(n);
            disp_valid <= 1'b1;
            disp_op <= nx_op;
            disp_rd <= nx_rd;
            disp_rs1 <= nx_rs1;
            disp_rs2 <= nx_rs2;
            disp_imm <= nx_imm;
            disp_has_imm <= nx_has_imm;
            disp_pc <= pc;
            pc = pc + 32'd4;
            waited = 0;
            @(negedge clk);
            while (!disp_ready) begin
                waited++;
                assert (waited < WAIT_LIMIT) else fail_run("dispatch handshake timed out");
                @(negedge clk);
            end
            @(posedge clk);
        end
        disp_valid <= 1'b0;
        waited = 0;
        while (commits < NUM_INSTR) begin
            waited++;
            assert (waited < DRAIN_LIMIT) else fail_run("outstanding instructions never committed");
            @(negedge clk);
        end
        if (stall_seen) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("disp_ready never dropped during the run");
        end
    end
endmodule
